// File: bench/soc_io_slaves.sv
`timescale 1ns/1ns

// ----------------------------------------------------------------------------
// AXI4-Lite register slave in place of the SD-card SPI controller
// ----------------------------------------------------------------------------
module spi_axil_slave #(
    parameter logic [7:0] FILL_TAG = 8'hC2          // Top byte of the power-up words
) (
    input  logic                      clk,
    input  soc_io_bus_pkg::axil_req_t axil_req_i,
    output soc_io_bus_pkg::axil_rsp_t axil_rsp_o,
    output int                        txn_count_o   // Completed transactions
);
    import soc_io_bus_pkg::*;

    xlen_t      mem [32];       // 32 registers, word addressed
    integer     seed;
    axil_addr_t addr;

    // 0 to 3 idle cycles, then on to the next drive point
    task random_wait();
        repeat ($random(seed) & 3) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed        = 64;
        axil_rsp_o  = '0;                           // Nothing valid, OKAY responses
        txn_count_o = 0;
        for (int i = 0; i < 32; i++)
            mem[i] = {FILL_TAG, 19'd0, i[4:0]};
        forever begin
            @(negedge clk);
            if (axil_req_i.awvalid && axil_req_i.wvalid) begin
                random_wait();
                axil_rsp_o.awready = 1'b1;
                addr = axil_req_i.awaddr;
                @(posedge clk);
                #1;
                axil_rsp_o.awready = 1'b0;
                random_wait();                      // Data taken after the address
                axil_rsp_o.wready = 1'b1;
                for (int b = 0; b < 4; b++)
                    if (axil_req_i.wstrb[b])
                        mem[addr[6:2]][8*b +: 8] = axil_req_i.wdata[8*b +: 8];
                @(posedge clk);
                #1;
                axil_rsp_o.wready = 1'b0;
                random_wait();
                axil_rsp_o.bvalid = 1'b1;           // Held until bready
                @(negedge clk);
                while (!axil_req_i.bready)
                    @(negedge clk);
                txn_count_o++;
                @(posedge clk);
                #1;
                axil_rsp_o.bvalid = 1'b0;
            end else if (axil_req_i.arvalid) begin
                random_wait();
                axil_rsp_o.arready = 1'b1;
                addr = axil_req_i.araddr;
                @(posedge clk);
                #1;
                axil_rsp_o.arready = 1'b0;
                random_wait();
                axil_rsp_o.rvalid = 1'b1;           // Held until rready
                axil_rsp_o.rdata  = mem[addr[6:2]];
                @(negedge clk);
                while (!axil_req_i.rready)
                    @(negedge clk);
                txn_count_o++;
                @(posedge clk);
                #1;
                axil_rsp_o.rvalid = 1'b0;
                axil_rsp_o.rdata  = '0;
            end
        end
    end

endmodule

// ----------------------------------------------------------------------------
// Local-bus slave in place of the UART controller
// ----------------------------------------------------------------------------
module uart_bus_slave #(
    parameter logic [7:0] FILL_TAG = 8'hC0
) (
    input  logic                     clk,
    input  soc_io_bus_pkg::dev_req_t req_i,
    output soc_io_bus_pkg::dev_rsp_t rsp_o,
    output int                       txn_count_o
);
    import soc_io_bus_pkg::*;

    xlen_t    mem [32];
    integer   seed;
    dev_req_t req;              // Fields captured with the strobe

    task random_wait();
        repeat ($random(seed) & 3) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed        = 64;
        rsp_o       = '0;
        txn_count_o = 0;
        for (int i = 0; i < 32; i++)
            mem[i] = {FILL_TAG, 19'd0, i[4:0]};
        forever begin
            @(negedge clk);
            if (req_i.strobe) begin
                req = req_i;
                random_wait();
                rsp_o.ready = 1'b1;                 // One-cycle pulse
                rsp_o.rdata = req.we ? '0 : mem[req.addr[6:2]];
                if (req.we) begin
                    for (int b = 0; b < 4; b++)
                        if (req.be[b])
                            mem[req.addr[6:2]][8*b +: 8] = req.wdata[8*b +: 8];
                end
                txn_count_o++;
                @(posedge clk);
                #1;
                rsp_o = '0;
            end
        end
    end

endmodule

// File: bench/soc_io_tb.sv
`timescale 1ns/1ns
`include "soc_io_defs.svh"

module soc_io_tb;
    import soc_io_bus_pkg::*;

    localparam int    N_ACCESSES     = 123;     // 16 + 16 + 8 + 3 + 16 + 64
    localparam int    TIMEOUT_CYCLES = 40 * N_ACCESSES + 100;
    localparam xlen_t UART_BASE      = 32'hC000_0000;
    localparam xlen_t SPI_BASE       = 32'hC200_0000;

    // One finished access as seen by its core
    typedef struct packed {
        logic [1:0] core;
        xlen_t      addr;
        logic       we;
        strb_t      be;
        xlen_t      wdata;
        xlen_t      rdata;
    } acc_rec_t;

    logic      clk;
    logic      usr_reset;
    dev_req_t  core_req [`CORE_NUMS];
    dev_rsp_t  core_rsp [`CORE_NUMS];
    dev_req_t  uart_req;
    dev_rsp_t  uart_rsp;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    int        spi_count;
    int        uart_count;
    integer    seed = 64;
    int        cycles = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    int        test_errs;
    string     test_name;
    acc_rec_t  done_q [$];              // Completed accesses in bus order
    xlen_t     uart_shadow [32];
    xlen_t     spi_shadow [32];

    soc_io_top dut_i (
        .clk        (clk),
        .usr_reset  (usr_reset),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .uart_req_o (uart_req),
        .uart_rsp_i (uart_rsp),
        .axil_req_o (axil_req),
        .axil_rsp_i (axil_rsp)
    );

    spi_axil_slave #(.FILL_TAG(8'hC2)) u_spi_slave (
        .clk (clk), .axil_req_i (axil_req), .axil_rsp_o (axil_rsp), .txn_count_o (spi_count)
    );

    uart_bus_slave #(.FILL_TAG(8'hC0)) u_uart_slave (
        .clk (clk), .req_i (uart_req), .rsp_o (uart_rsp), .txn_count_o (uart_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, an access never completed", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference model with a byte-merged shadow of both slave memories
    // ------------------------------------------------------------------------
    function automatic xlen_t expected_word(input acc_rec_t rec);
        xlen_t      word;
        logic [4:0] idx;
        idx  = rec.addr[6:2];
        word = '0;                                  // Unmapped reads give zero
        if (rec.addr[31:24] == 8'hC0)
            word = uart_shadow[idx];
        else if (rec.addr[31:24] == 8'hC2)
            word = spi_shadow[idx];
        if (rec.we) begin
            for (int b = 0; b < 4; b++)
                if (rec.be[b])
                    word[8*b +: 8] = rec.wdata[8*b +: 8];
            if (rec.addr[31:24] == 8'hC0)
                uart_shadow[idx] = word;
            else if (rec.addr[31:24] == 8'hC2)
                spi_shadow[idx] = word;
            expected_word = '0;                     // Writes return zero data
        end else begin
            expected_word = word;
        end
    endfunction

    // Compare every finished access against the reference
    initial begin
        acc_rec_t rec;
        xlen_t    exp_word;
        forever begin
            @(negedge clk);
            while (done_q.size() != 0) begin
                rec      = done_q.pop_front();
                exp_word = expected_word(rec);
                if (rec.rdata !== exp_word) begin
                    $display("[FAIL] %s: core %0d %s %h expected %h actual %h", test_name,
                             rec.core, rec.we ? "write" : "read", rec.addr, exp_word,
                             rec.rdata);
                    fail_count++;
                    test_errs++;
                end else begin
                    pass_count++;
                end
            end
        end
    end

    // One strobe on a core port and a wait for its ready pulse
    task automatic core_access(input int core, input xlen_t addr, input logic we,
                               input strb_t be, input xlen_t wdata, output int done_cyc);
        acc_rec_t rec;
        core_req[core] = '{strobe: 1'b1, addr: addr, we: we, be: be, wdata: wdata};
        @(posedge clk);
        #1;
        core_req[core].strobe = 1'b0;
        @(negedge clk);
        while (!core_rsp[core].ready)
            @(negedge clk);
        rec = '{core: core[1:0], addr: addr, we: we, be: be, wdata: wdata,
                rdata: core_rsp[core].rdata};
        done_cyc = cycles;
        done_q.push_back(rec);
        @(posedge clk);
        #1;
    endtask

    // Single access with a check that only the addressed slave saw it
    task automatic run_access(input int core, input xlen_t addr, input logic we,
                              input strb_t be, input xlen_t wdata);
        int spi_exp;
        int uart_exp;
        int done_cyc;
        spi_exp  = spi_count + (addr[31:24] == 8'hC2);
        uart_exp = uart_count + (addr[31:24] == 8'hC0);
        core_access(core, addr, we, be, wdata, done_cyc);
        if (spi_count != spi_exp || uart_count != uart_exp) begin
            $display("[FAIL] %s: counts at %h expected spi %0d uart %0d actual spi %0d uart %0d",
                     test_name, addr, spi_exp, uart_exp, spi_count, uart_count);
            fail_count++;
            test_errs++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_order(input int c0, input int c1);
        if (c0 >= c1) begin
            $display("%s: core 0 ready at cycle %0d did not come before core 1 ready at cycle %0d",
                     test_name, c0, c1);
            fail_count++;
            test_errs++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        while (done_q.size() != 0)
            @(negedge clk);
        $display("Test %-22s %s", test_name, (test_errs == 0) ? "ok" : "with errors");
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int    k;
        int    r;
        int    c0;
        int    c1;
        int    total_start;
        xlen_t base;
        xlen_t a0;
        xlen_t a1;
        usr_reset = 1'b1;
        for (int i = 0; i < `CORE_NUMS; i++)
            core_req[i] = '0;
        for (int i = 0; i < 32; i++) begin
            uart_shadow[i] = {8'hC0, 19'd0, i[4:0]};  // Same power-up fill as the slaves
            spi_shadow[i]  = {8'hC2, 19'd0, i[4:0]};
        end
        repeat (2) @(posedge clk);
        #1;
        usr_reset = 1'b0;
        repeat (`RST_STRETCH + 2) @(posedge clk);     // Internal reset runs out
        #1;

        start_test("spi_write_read");
        for (k = 0; k < 8; k++)
            run_access(0, SPI_BASE + 4 * k, 1'b1, 4'hF, $random(seed));
        for (k = 0; k < 8; k++)
            run_access(0, SPI_BASE + 4 * k, 1'b0, 4'hF, '0);
        finish_test();

        start_test("byte_enable_merge");
        for (r = 0; r < 2; r++) begin
            base = (r == 0) ? UART_BASE : SPI_BASE;
            for (k = 8; k < 10; k++) begin
                run_access(1, base + 4 * k, 1'b1, 4'b0101, $random(seed));
                run_access(1, base + 4 * k, 1'b1, 4'b1000, $random(seed));
                run_access(1, base + 4 * k, 1'b1, 4'b0010, $random(seed));
                run_access(1, base + 4 * k, 1'b0, 4'hF, '0);
            end
        end
        finish_test();

        start_test("uart_routing");
        for (k = 0; k < 4; k++) begin
            run_access(0, UART_BASE + 4 * k, 1'b1, 4'hF, $random(seed));
            run_access(0, UART_BASE + 4 * k, 1'b0, 4'hF, '0);
        end
        finish_test();

        start_test("unmapped_access");
        run_access(0, 32'hC100_0010, 1'b0, 4'hF, '0);
        run_access(0, 32'hC300_0004, 1'b1, 4'hF, $random(seed));
        run_access(1, 32'h8000_0000, 1'b0, 4'hF, '0);    // Core 1 goes last so core 0 wins next
        finish_test();

        // Both cores strobe in the same cycle
        // Core 0 owns words 16 to 23 and core 1 owns words 24 to 31
        start_test("two_core_round_robin");
        total_start = spi_count + uart_count;
        for (r = 0; r < 4; r++) begin
            a0 = (($random(seed) & 1) ? SPI_BASE : UART_BASE) + 4 * (16 + ($random(seed) & 7));
            a1 = (($random(seed) & 1) ? SPI_BASE : UART_BASE) + 4 * (24 + ($random(seed) & 7));
            fork
                core_access(0, a0, 1'b1, 4'hF, $random(seed), c0);
                core_access(1, a1, 1'b1, 4'hF, $random(seed), c1);
            join
            check_order(c0, c1);
            fork
                core_access(0, a0, 1'b0, 4'hF, '0, c0);
                core_access(1, a1, 1'b0, 4'hF, '0, c1);
            join
            check_order(c0, c1);
        end
        if (spi_count + uart_count - total_start != 16) begin
            $display("[FAIL] %s: slave transactions expected 16 actual %0d",
                     test_name, spi_count + uart_count - total_start);
            fail_count++;
            test_errs++;
        end else begin
            pass_count++;
        end
        finish_test();

        start_test("backpressure");
        for (k = 0; k < 64; k++) begin
            r    = $random(seed) & 7;
            base = (r == 7) ? 32'hC500_0000 : (r[0] ? SPI_BASE : UART_BASE);
            run_access($random(seed) & 1, base + 4 * ($random(seed) & 31),
                       ($random(seed) & 1) != 0, strb_t'($random(seed)), $random(seed));
        end
        finish_test();

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: design/dev_to_axil_bridge.sv
`timescale 1ns/1ns
`include "soc_io_defs.svh"

module dev_to_axil_bridge (
    input  logic                      clk,
    input  logic                      rst_i,
    input  soc_io_bus_pkg::dev_req_t  dev_req_i,
    output soc_io_bus_pkg::dev_rsp_t  dev_rsp_o,
    output soc_io_bus_pkg::axil_req_t axil_req_o,
    input  soc_io_bus_pkg::axil_rsp_t axil_rsp_i
);
    import soc_io_bus_pkg::*;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_WRITE,       // awvalid and wvalid out
        BR_WR_RESP,     // Waiting for bvalid
        BR_RD_ADDR,     // arvalid out
        BR_RD_DATA      // Waiting for rvalid
    } br_state_t;

    br_state_t  state;
    logic       aw_valid_q, w_valid_q, b_ready_q;
    logic       ar_valid_q, r_ready_q;
    logic       aw_done, w_done;        // Channel handshake seen
    logic       aw_hs, w_hs;
    logic       aw_fin, w_fin;
    logic       rsp_ready_q;
    axil_addr_t addr_q;
    xlen_t      wdata_q;
    strb_t      wstrb_q;
    xlen_t      rdata_q;

    assign aw_hs  = aw_valid_q & axil_rsp_i.awready;
    assign w_hs   = w_valid_q & axil_rsp_i.wready;
    assign aw_fin = aw_done | aw_hs;    // Address accepted, now or earlier
    assign w_fin  = w_done | w_hs;

    // ------------------------------------------------------------------------
    // Transaction FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= BR_IDLE;
            aw_valid_q  <= 1'b0;
            w_valid_q   <= 1'b0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            b_ready_q   <= 1'b0;
            ar_valid_q  <= 1'b0;
            r_ready_q   <= 1'b0;
            rsp_ready_q <= 1'b0;
        end else begin
            rsp_ready_q <= 1'b0;
            case (state)
                BR_IDLE: begin
                    if (dev_req_i.strobe && dev_req_i.we) begin
                        aw_valid_q <= 1'b1;     // Address and data go out together
                        w_valid_q  <= 1'b1;
                        aw_done    <= 1'b0;
                        w_done     <= 1'b0;
                        state      <= BR_WRITE;
                    end else if (dev_req_i.strobe) begin
                        ar_valid_q <= 1'b1;
                        state      <= BR_RD_ADDR;
                    end
                end
                BR_WRITE: begin
                    if (aw_hs) begin
                        aw_valid_q <= 1'b0;     // Each channel drops on its own
                        aw_done    <= 1'b1;
                    end
                    if (w_hs) begin
                        w_valid_q <= 1'b0;
                        w_done    <= 1'b1;
                    end
                    if (aw_fin && w_fin) begin
                        b_ready_q <= 1'b1;
                        state     <= BR_WR_RESP;
                    end
                end
                BR_WR_RESP: begin
                    if (axil_rsp_i.bvalid) begin   // BRESP not checked
                        b_ready_q   <= 1'b0;
                        rsp_ready_q <= 1'b1;
                        state       <= BR_IDLE;
                    end
                end
                BR_RD_ADDR: begin
                    if (axil_rsp_i.arready) begin
                        ar_valid_q <= 1'b0;
                        r_ready_q  <= 1'b1;
                        state      <= BR_RD_DATA;
                    end
                end
                BR_RD_DATA: begin
                    if (axil_rsp_i.rvalid) begin   // RRESP not checked
                        r_ready_q   <= 1'b0;
                        rsp_ready_q <= 1'b1;
                        state       <= BR_IDLE;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (state == BR_IDLE && dev_req_i.strobe) begin
            addr_q  <= dev_req_i.addr[`AXIL_ADDR_W-1:0];   // Register offset only
            wdata_q <= dev_req_i.wdata;
            wstrb_q <= dev_req_i.be;
        end
        if (state == BR_WR_RESP && axil_rsp_i.bvalid)
            rdata_q <= '0;
        else if (state == BR_RD_DATA && axil_rsp_i.rvalid)
            rdata_q <= axil_rsp_i.rdata;
    end

    always_comb begin
        axil_req_o.awvalid = aw_valid_q;
        axil_req_o.awaddr  = addr_q;
        axil_req_o.wvalid  = w_valid_q;
        axil_req_o.wdata   = wdata_q;
        axil_req_o.wstrb   = wstrb_q;
        axil_req_o.bready  = b_ready_q;
        axil_req_o.arvalid = ar_valid_q;
        axil_req_o.araddr  = addr_q;
        axil_req_o.rready  = r_ready_q;
    end

    assign dev_rsp_o.ready = rsp_ready_q;
    assign dev_rsp_o.rdata = rdata_q;

    // Address valids hold under back-pressure
    a_aw_hold: assert property (@(posedge clk) disable iff (rst_i)
        (axil_req_o.awvalid && !axil_rsp_i.awready) |=> axil_req_o.awvalid);

    a_ar_hold: assert property (@(posedge clk) disable iff (rst_i)
        (axil_req_o.arvalid && !axil_rsp_i.arready) |=> axil_req_o.arvalid);

endmodule

// File: design/device_arbiter.sv
`timescale 1ns/1ns
`include "soc_io_defs.svh"

module device_arbiter (
    input  logic                     clk,
    input  logic                     rst_i,
    input  soc_io_bus_pkg::dev_req_t core_req_i [`CORE_NUMS],
    output soc_io_bus_pkg::dev_rsp_t core_rsp_o [`CORE_NUMS],
    output soc_io_bus_pkg::dev_req_t dev_req_o,
    input  soc_io_bus_pkg::dev_rsp_t dev_rsp_i
);
    import soc_io_bus_pkg::*;

    typedef enum logic {
        ARB_IDLE,   // Bus free
        ARB_BUSY    // One access forwarded, waiting for ready
    } arb_state_t;

    arb_state_t             state;
    logic [`CORE_NUMS-1:0]  pend_valid;             // Latched request per core
    dev_req_t               pend_req [`CORE_NUMS];  // Latched fields per core
    core_id_t               last_id;                // Last granted core, owner while busy
    logic                   fwd_strobe;             // Forwarded strobe pulse
    dev_req_t               fwd_q;                  // Forwarded fields, held until ready
    logic                   win_found;
    core_id_t               win_id;

    // ------------------------------------------------------------------------
    // Round-robin pick, search starts right after the last granted core
    // ------------------------------------------------------------------------
    always_comb begin
        int unsigned idx;
        win_found = 1'b0;
        win_id    = last_id;
        for (int k = 1; k <= `CORE_NUMS; k++) begin
            idx = (int'(last_id) + k) % `CORE_NUMS;
            if (!win_found && pend_valid[idx]) begin
                win_found = 1'b1;
                win_id    = core_id_t'(idx);
            end
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= ARB_IDLE;
            pend_valid <= '0;
            last_id    <= core_id_t'(`CORE_NUMS - 1);  // So core 0 wins first
            fwd_strobe <= 1'b0;
        end else begin
            fwd_strobe <= 1'b0;                     // Strobe lasts one cycle
            case (state)
                ARB_IDLE: begin
                    if (win_found) begin
                        state              <= ARB_BUSY;
                        last_id            <= win_id;
                        fwd_strobe         <= 1'b1;
                        pend_valid[win_id] <= 1'b0;
                    end
                end
                ARB_BUSY: begin
                    if (dev_rsp_i.ready)
                        state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
            // New strobes take priority over the grant clear
            for (int i = 0; i < `CORE_NUMS; i++) begin
                if (core_req_i[i].strobe)
                    pend_valid[i] <= 1'b1;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `CORE_NUMS; i++) begin
            if (core_req_i[i].strobe)
                pend_req[i] <= core_req_i[i];
        end
        if (state == ARB_IDLE && win_found)
            fwd_q <= pend_req[win_id];
    end

    always_comb begin
        dev_req_o        = fwd_q;
        dev_req_o.strobe = fwd_strobe;
    end

    // Ready and data go back to the owner only
    always_comb begin
        for (int i = 0; i < `CORE_NUMS; i++) begin
            if (state == ARB_BUSY && last_id == core_id_t'(i)) begin
                core_rsp_o[i] = dev_rsp_i;
            end else begin
                core_rsp_o[i].ready = 1'b0;
                core_rsp_o[i].rdata = '0;
            end
        end
    end

    // A forwarded access stays alone on the bus until its ready returns
    a_one_in_flight: assert property (@(posedge clk) disable iff (rst_i)
        dev_req_o.strobe |=> (!dev_req_o.strobe until_with dev_rsp_i.ready));

endmodule

// File: design/device_decoder.sv
`timescale 1ns/1ns

module device_decoder (
    input  logic                     clk,
    input  logic                     rst_i,
    input  soc_io_bus_pkg::dev_req_t dev_req_i,
    output soc_io_bus_pkg::dev_rsp_t dev_rsp_o,
    output soc_io_bus_pkg::dev_req_t uart_req_o,
    input  soc_io_bus_pkg::dev_rsp_t uart_rsp_i,
    output soc_io_bus_pkg::dev_req_t spi_req_o,
    input  soc_io_bus_pkg::dev_rsp_t spi_rsp_i
);
    import soc_io_bus_pkg::*;
    import soc_io_map_pkg::*;

    region_t region;        // Region byte of the current request
    region_t region_q;      // Region of the access in flight
    region_t rsp_sel;
    logic    is_uart;
    logic    is_spi;
    logic    unmap_ready;   // Built-in responder pulse

    assign region  = region_t'(dev_req_i.addr[REGION_LSB +: $bits(region_t)]);
    assign is_uart = (region == REGION_UART);
    assign is_spi  = (region == REGION_SPI);

    // Fields fan out to both targets and the strobe to one only
    always_comb begin
        uart_req_o        = dev_req_i;
        uart_req_o.strobe = dev_req_i.strobe & is_uart;
        spi_req_o         = dev_req_i;
        spi_req_o.strobe  = dev_req_i.strobe & is_spi;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            region_q    <= region_t'(8'h00);    // Unmapped code so the response idles low
            unmap_ready <= 1'b0;
        end else begin
            unmap_ready <= dev_req_i.strobe & ~is_uart & ~is_spi;
            if (dev_req_i.strobe)
                region_q <= region;
        end
    end

    // ------------------------------------------------------------------------
    // Response select
    // ------------------------------------------------------------------------
    assign rsp_sel = dev_req_i.strobe ? region : region_q;  // Covers same-cycle ready

    always_comb begin
        case (rsp_sel)
            REGION_UART: dev_rsp_o = uart_rsp_i;
            REGION_SPI:  dev_rsp_o = spi_rsp_i;
            default: begin
                dev_rsp_o.ready = unmap_ready;
                dev_rsp_o.rdata = '0;
            end
        endcase
    end

    a_one_target: assert property (@(posedge clk) disable iff (rst_i)
        !(uart_req_o.strobe && spi_req_o.strobe));

endmodule

// File: design/soc_io_bus_pkg.sv
`include "soc_io_defs.svh"

package soc_io_bus_pkg;

    typedef logic [`XLEN-1:0]              xlen_t;      // One address or data word
    typedef logic [`XLEN/8-1:0]            strb_t;      // Byte enables
    typedef logic [$clog2(`CORE_NUMS)-1:0] core_id_t;   // Processor port index
    typedef logic [`AXIL_ADDR_W-1:0]       axil_addr_t; // SPI register offset

    // ------------------------------------------------------------------------
    // Device bus, strobe/ready handshake
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic  strobe;  // One-cycle request pulse
        xlen_t addr;
        logic  we;      // 1 = write, 0 = read
        strb_t be;
        xlen_t wdata;
    } dev_req_t;

    typedef struct packed {
        logic  ready;   // One-cycle completion pulse
        xlen_t rdata;   // Zero for writes
    } dev_rsp_t;

    // ------------------------------------------------------------------------
    // AXI4-Lite, master side and slave side
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        xlen_t      wdata;
        strb_t      wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        xlen_t      rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

// File: design/soc_io_map_pkg.sv
package soc_io_map_pkg;

    // Device regions, selected by the top address byte
    //   C0xx_xxxx : UART local bus
    //   C2xx_xxxx : SD-card SPI controller, behind AXI4-Lite
    //   Any other value is unmapped and answered by the decoder itself
    typedef enum logic [7:0] {
        REGION_UART = 8'hC0,
        REGION_SPI  = 8'hC2
    } region_t;

    // Lowest bit of the region byte in a device address
    localparam int REGION_LSB = 24;

endpackage

// File: design/soc_io_top.sv
`timescale 1ns/1ns
`include "soc_io_defs.svh"

module soc_io_top (
    input  logic                      clk,
    input  logic                      usr_reset,
    input  soc_io_bus_pkg::dev_req_t  core_req_i [`CORE_NUMS],
    output soc_io_bus_pkg::dev_rsp_t  core_rsp_o [`CORE_NUMS],
    output soc_io_bus_pkg::dev_req_t  uart_req_o,
    input  soc_io_bus_pkg::dev_rsp_t  uart_rsp_i,
    output soc_io_bus_pkg::axil_req_t axil_req_o,
    input  soc_io_bus_pkg::axil_rsp_t axil_rsp_i
);
    import soc_io_bus_pkg::*;

    logic [`RST_STRETCH-1:0] rst_sr;    // Reset stretch shift register
    logic                    rst;       // Internal reset for all blocks
    dev_req_t                arb_req;   // Granted access
    dev_rsp_t                arb_rsp;
    dev_req_t                spi_req;   // SPI region access to the bridge
    dev_rsp_t                spi_rsp;

    // ------------------------------------------------------------------------
    // Reset stretcher, high for RST_STRETCH cycles after usr_reset falls
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (usr_reset)
            rst_sr <= '1;
        else
            rst_sr <= {rst_sr[`RST_STRETCH-2:0], 1'b0};
    end

    assign rst = rst_sr[`RST_STRETCH-1];

    device_arbiter u_arbiter (
        .clk        (clk),
        .rst_i      (rst),
        .core_req_i (core_req_i),
        .core_rsp_o (core_rsp_o),
        .dev_req_o  (arb_req),
        .dev_rsp_i  (arb_rsp)
    );

    // Address decoder, UART out directly, SPI through the bridge
    device_decoder u_decoder (
        .clk        (clk),
        .rst_i      (rst),
        .dev_req_i  (arb_req),
        .dev_rsp_o  (arb_rsp),
        .uart_req_o (uart_req_o),
        .uart_rsp_i (uart_rsp_i),
        .spi_req_o  (spi_req),
        .spi_rsp_i  (spi_rsp)
    );

    dev_to_axil_bridge u_spi_bridge (
        .clk        (clk),
        .rst_i      (rst),
        .dev_req_i  (spi_req),
        .dev_rsp_o  (spi_rsp),
        .axil_req_o (axil_req_o),
        .axil_rsp_i (axil_rsp_i)
    );

endmodule

// File: include/soc_io_defs.svh
`ifndef SOC_IO_DEFS_SVH
`define SOC_IO_DEFS_SVH

// Width of device-bus addresses and data words
`define XLEN        32

// Processor ports sharing the device bus, 2 or 4
`define CORE_NUMS   2

// Cycles the internal reset stays high after usr_reset drops
`define RST_STRETCH 5

// Address width of the SPI register window on AXI4-Lite
`define AXIL_ADDR_W 7

`endif

// File: soc_io.f
+incdir+include
design/soc_io_bus_pkg.sv
design/soc_io_map_pkg.sv
design/device_arbiter.sv
design/device_decoder.sv
design/dev_to_axil_bridge.sv
design/soc_io_top.sv
bench/soc_io_slaves.sv
bench/soc_io_tb.sv
